// File: Makefile
# Verilator build and run of the node memory testbench

SIM       := verilator
SIM_FLAGS := --binary --assert -j 0
TOP       := tb_nx_node_memory
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# The run fails through $$fatal, which gives a nonzero exit status
sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: filelist.f
+incdir+test
logic/nx_mem_pkg.sv
logic/nx_ram_port_if.sv
logic/nx_ram.sv
logic/nx_msg_decoder.sv
logic/nx_range_engine.sv
logic/nx_node_memory.sv
test/tb_nx_node_memory.sv

// File: logic/nx_mem_pkg.sv
/*
 * Shared definitions for the node memory
 * Host message opcode enum and range engine command enum
 */
package nx_mem_pkg;

    // Host message opcode, arrives on msg_op_i with msg_valid_i
    typedef enum logic {
        MSG_READ  = 1'b0, // Read one word, tagged response next cycle
        MSG_WRITE = 1'b1  // Write one word, no response
    } nx_msg_op_t;

    // Range engine command, arrives on cmd_op_i with cmd_start_i
    typedef enum logic {
        RANGE_READ = 1'b0, // Stream the block out in address order
        RANGE_FILL = 1'b1  // Write the fill value into every word of the block
    } nx_range_op_t;

endpackage : nx_mem_pkg

// File: logic/nx_msg_decoder.sv
/*
 * Host message decoder on RAM port A
 * Turns read and write messages into port accesses
 * Returns tagged read responses one cycle after the read
 */
`timescale 1ns/1ps

module nx_msg_decoder #(
      parameter int ADDR_W = 10
    , parameter int DATA_W = 36
    , parameter int TAG_W  = 4
) (
      input  logic                   clk_a_i
    , input  logic                   rst_a_i
    // Inbound host message, one per cycle, no back-pressure
    , input  logic                   msg_valid_i
    , input  nx_mem_pkg::nx_msg_op_t msg_op_i
    , input  logic [TAG_W-1:0]       msg_tag_i
    , input  logic [ADDR_W-1:0]      msg_addr_i
    , input  logic [DATA_W-1:0]      msg_data_i
    // RAM port A
    , nx_ram_port_if.controller      ram_o
    // Read response
    , output logic                   rsp_valid_o
    , output logic [TAG_W-1:0]       rsp_tag_o
    , output logic [DATA_W-1:0]      rsp_data_o
);

    import nx_mem_pkg::*;

    logic             is_write;  // Current message is a write
    logic             is_read;   // Current message is a read
    logic             rd_pend_q; // Read issued last cycle
    logic [TAG_W-1:0] tag_q;     // Tag of that read

    // Opcode decode
    assign is_write = msg_valid_i && (msg_op_i == MSG_WRITE);
    assign is_read  = msg_valid_i && (msg_op_i == MSG_READ);

    // Message fields go straight onto the port
    assign ram_o.en      = msg_valid_i;   // Access on any message
    assign ram_o.wr_en   = is_write;
    assign ram_o.addr    = msg_addr_i;
    assign ram_o.wr_data = msg_data_i;    // Ignored by the RAM on reads

    // Pending read flag, lines up with rd_data one cycle later
    always_ff @(posedge clk_a_i or posedge rst_a_i) begin : ff_rd_pend
        if (rst_a_i) begin
            rd_pend_q <= 1'b0;
        end else begin
            rd_pend_q <= is_read;
        end
    end

    // Tag follows the read through the RAM latency
    always_ff @(posedge clk_a_i) begin : ff_tag
        if (is_read) begin
            tag_q <= msg_tag_i;
        end
    end

    // Response
    // Data comes from the port A read register with no extra stage
    assign rsp_valid_o = rd_pend_q;
    assign rsp_tag_o   = tag_q;
    assign rsp_data_o  = ram_o.rd_data;

    // An unknown opcode would pick neither read nor write
    a_msg_op_known : assert property (@(posedge clk_a_i) disable iff (rst_a_i)
        msg_valid_i |-> !$isunknown(msg_op_i))
        else $error("nx_msg_decoder: unknown opcode on a valid message");

endmodule : nx_msg_decoder

// File: logic/nx_node_memory.sv
/*
 * Node local memory top level
 * Host message decoder on port A, range engine on port B, shared dual-port RAM
 */
`timescale 1ns/1ps

module nx_node_memory #(
      parameter int ADDR_W = 10
    , parameter int DATA_W = 36
    , parameter int DEPTH  = 1024
    , parameter int TAG_W  = 4
    , parameter int CNT_W  = 11
) (
      input  logic                     clk_a_i
    , input  logic                     rst_a_i
    // Host message in
    , input  logic                     msg_valid_i
    , input  nx_mem_pkg::nx_msg_op_t   msg_op_i
    , input  logic [TAG_W-1:0]         msg_tag_i
    , input  logic [ADDR_W-1:0]        msg_addr_i
    , input  logic [DATA_W-1:0]        msg_data_i
    // Host response out
    , output logic                     rsp_valid_o
    , output logic [TAG_W-1:0]         rsp_tag_o
    , output logic [DATA_W-1:0]        rsp_data_o
    // Range command in
    , input  logic                     cmd_start_i
    , input  nx_mem_pkg::nx_range_op_t cmd_op_i
    , input  logic [ADDR_W-1:0]        cmd_addr_i
    , input  logic [CNT_W-1:0]         cmd_count_i
    , input  logic [DATA_W-1:0]        cmd_fill_i
    // Range results out
    , output logic                     busy_o
    , output logic                     stream_valid_o
    , output logic [DATA_W-1:0]        stream_data_o
    , output logic                     done_o
);

    // RAM ports, A for the network and B for the range engine
    nx_ram_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) port_a ();
    nx_ram_port_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) port_b ();

    // Host messages
    nx_msg_decoder #(
          .ADDR_W     (ADDR_W)
        , .DATA_W     (DATA_W)
        , .TAG_W      (TAG_W)
    ) u_msg_decoder (
          .clk_a_i    (clk_a_i)
        , .rst_a_i    (rst_a_i)
        , .msg_valid_i(msg_valid_i)
        , .msg_op_i   (msg_op_i)
        , .msg_tag_i  (msg_tag_i)
        , .msg_addr_i (msg_addr_i)
        , .msg_data_i (msg_data_i)
        , .ram_o      (port_a)
        , .rsp_valid_o(rsp_valid_o)
        , .rsp_tag_o  (rsp_tag_o)
        , .rsp_data_o (rsp_data_o)
    );

    // Block read and fill
    nx_range_engine #(
          .ADDR_W        (ADDR_W)
        , .DATA_W        (DATA_W)
        , .DEPTH         (DEPTH)
        , .CNT_W         (CNT_W)
    ) u_range_engine (
          .clk_a_i       (clk_a_i)
        , .rst_a_i       (rst_a_i)
        , .cmd_start_i   (cmd_start_i)
        , .cmd_op_i      (cmd_op_i)
        , .cmd_addr_i    (cmd_addr_i)
        , .cmd_count_i   (cmd_count_i)
        , .cmd_fill_i    (cmd_fill_i)
        , .ram_o         (port_b)
        , .busy_o        (busy_o)
        , .stream_valid_o(stream_valid_o)
        , .stream_data_o (stream_data_o)
        , .done_o        (done_o)
    );

    // Shared storage
    nx_ram #(
          .ADDR_W  (ADDR_W)
        , .DATA_W  (DATA_W)
        , .DEPTH   (DEPTH)
    ) u_ram (
          .clk_a_i (clk_a_i)
        , .rst_a_i (rst_a_i)
        , .port_a_i(port_a)
        , .port_b_i(port_b)
    );

endmodule : nx_node_memory

// File: logic/nx_ram.sv
/*
 * Behavioral true dual-port RAM, both ports on one clock
 * Read-first on each port, read data registers cleared by reset
 */
`timescale 1ns/1ps

module nx_ram #(
      parameter int ADDR_W = 10
    , parameter int DATA_W = 36
    , parameter int DEPTH  = 1024
) (
      input  logic                 clk_a_i
    , input  logic                 rst_a_i
    , nx_ram_port_if.memory        port_a_i // Network side
    , nx_ram_port_if.memory        port_b_i // Range engine side
);

    // Storage, contents undefined after reset
    logic [DATA_W-1:0] memory [DEPTH];

    logic wr_a; // Port A write this cycle
    logic wr_b; // Port B write this cycle
    logic rd_a; // Port A read this cycle
    logic rd_b; // Port B read this cycle

    assign wr_a = port_a_i.en && port_a_i.wr_en;
    assign wr_b = port_b_i.en && port_b_i.wr_en;
    assign rd_a = port_a_i.en && !port_a_i.wr_en;
    assign rd_b = port_b_i.en && !port_b_i.wr_en;

    // Array writes from both ports, one process so the array has one driver
    always_ff @(posedge clk_a_i) begin : ff_write
        if (wr_a) begin
            memory[port_a_i.addr] <= port_a_i.wr_data;
        end
        if (wr_b) begin
            memory[port_b_i.addr] <= port_b_i.wr_data;
        end
    end

    // Read registers
    // Nonblocking read sees the word before any write at the same edge
    always_ff @(posedge clk_a_i or posedge rst_a_i) begin : ff_read
        if (rst_a_i) begin
            port_a_i.rd_data <= '0;
            port_b_i.rd_data <= '0;
        end else begin
            if (rd_a) begin
                port_a_i.rd_data <= memory[port_a_i.addr]; // Held on write
            end
            if (rd_b) begin
                port_b_i.rd_data <= memory[port_b_i.addr];
            end
        end
    end

    // Both controllers must stay inside the array
    a_addr_range : assert property (@(posedge clk_a_i) disable iff (rst_a_i)
        (port_a_i.en |-> (port_a_i.addr < DEPTH)) and
        (port_b_i.en |-> (port_b_i.addr < DEPTH)))
        else $error("nx_ram: enabled address beyond DEPTH");

    // Host traffic is held off while the range engine runs, so no shared write
    a_no_write_collision : assert property (@(posedge clk_a_i) disable iff (rst_a_i)
        (wr_a && wr_b) |-> (port_a_i.addr != port_b_i.addr))
        else $error("nx_ram: both ports wrote address %0d", port_a_i.addr);

endmodule : nx_ram

// File: logic/nx_ram_port_if.sv
/*
 * One RAM port bundle
 * Controller side drives address, data and enables, memory side returns read data
 */
`timescale 1ns/1ps

interface nx_ram_port_if #(
      parameter int ADDR_W = 10
    , parameter int DATA_W = 36
);

    logic [ADDR_W-1:0] addr;    // Word address
    logic [DATA_W-1:0] wr_data; // Write word
    logic              wr_en;   // Write when en is also high
    logic              en;      // Access this cycle
    logic [DATA_W-1:0] rd_data; // Registered read word

    // Block that issues accesses
    modport controller (
        output addr, wr_data, wr_en, en,
        input  rd_data
    );

    // RAM side
    modport memory (
        input  addr, wr_data, wr_en, en,
        output rd_data
    );

endinterface : nx_ram_port_if

// File: logic/nx_range_engine.sv
/*
 * Range engine on RAM port B
 * Walks count consecutive words from a start address, wrapping at DEPTH
 * Streams the words out or writes a fill value, one word per cycle
 */
`timescale 1ns/1ps

module nx_range_engine #(
      parameter int ADDR_W = 10
    , parameter int DATA_W = 36
    , parameter int DEPTH  = 1024
    , parameter int CNT_W  = 11
) (
      input  logic                     clk_a_i
    , input  logic                     rst_a_i
    // Command, single-cycle strobe
    , input  logic                     cmd_start_i
    , input  nx_mem_pkg::nx_range_op_t cmd_op_i
    , input  logic [ADDR_W-1:0]        cmd_addr_i
    , input  logic [CNT_W-1:0]         cmd_count_i
    , input  logic [DATA_W-1:0]        cmd_fill_i
    // RAM port B
    , nx_ram_port_if.controller        ram_o
    // Results
    , output logic                     busy_o
    , output logic                     stream_valid_o
    , output logic [DATA_W-1:0]        stream_data_o
    , output logic                     done_o
);

    import nx_mem_pkg::*;

    logic               busy_q;   // Accessing the RAM this cycle
    logic [ADDR_W-1:0]  addr_q;   // Address of the current access
    logic [CNT_W-1:0]   remain_q; // Accesses left including this one
    nx_range_op_t       op_q;     // Latched opcode
    logic [DATA_W-1:0]  fill_q;   // Latched fill value
    logic               rd_vld_q; // Read issued last cycle
    logic               done_q;   // Last access was last cycle
    logic               last;     // This is the final access
    logic [ADDR_W-1:0]  addr_nxt; // Next address with wrap

    assign last = busy_q && (remain_q == CNT_W'(1));

    // Wrap at DEPTH, which need not be a power of two
    assign addr_nxt = (addr_q == ADDR_W'(DEPTH - 1)) ? '0 : addr_q + 1'b1;

    // Command latch and walk
    always_ff @(posedge clk_a_i or posedge rst_a_i) begin : ff_walk
        if (rst_a_i) begin
            busy_q   <= 1'b0;
            addr_q   <= '0;
            remain_q <= '0;
            op_q     <= RANGE_READ;
        end else if (cmd_start_i) begin
            busy_q   <= 1'b1;          // First access next cycle
            addr_q   <= cmd_addr_i;
            remain_q <= cmd_count_i;
            op_q     <= cmd_op_i;
        end else if (busy_q) begin
            busy_q   <= !last;         // Drop in the done cycle
            addr_q   <= addr_nxt;
            remain_q <= remain_q - 1'b1;
        end
    end

    // Fill value is payload only
    always_ff @(posedge clk_a_i) begin : ff_fill
        if (cmd_start_i) begin
            fill_q <= cmd_fill_i;
        end
    end

    // Read flag and done follow the access by one cycle, as rd_data does
    always_ff @(posedge clk_a_i or posedge rst_a_i) begin : ff_result
        if (rst_a_i) begin
            rd_vld_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            rd_vld_q <= busy_q && (op_q == RANGE_READ);
            done_q   <= last;
        end
    end

    // Port B drive, one access per busy cycle
    assign ram_o.en      = busy_q;
    assign ram_o.wr_en   = busy_q && (op_q == RANGE_FILL);
    assign ram_o.addr    = addr_q;
    assign ram_o.wr_data = fill_q;

    // Results
    assign busy_o         = busy_q;
    assign stream_valid_o = rd_vld_q;
    assign stream_data_o  = ram_o.rd_data; // Port B read register
    assign done_o         = done_q;

    // Commands are only issued while idle, including the done cycle
    a_no_start_busy : assert property (@(posedge clk_a_i) disable iff (rst_a_i)
        cmd_start_i |-> !busy_q)
        else $error("nx_range_engine: start while busy");

    // Zero count would leave the engine busy for a full counter wrap
    a_count_nonzero : assert property (@(posedge clk_a_i) disable iff (rst_a_i)
        cmd_start_i |-> (cmd_count_i != '0))
        else $error("nx_range_engine: start with zero count");

endmodule : nx_range_engine

// File: test/nx_tb_model.svh
/*
 * Testbench helpers for the node memory
 * LCG random source, address wrap and the reference memory model
 */
`ifndef NX_TB_MODEL_SVH
`define NX_TB_MODEL_SVH

logic [31:0]       lcg_state = 32'hb7516cc3; // Fixed seed
logic [DATA_W-1:0] model_mem [DEPTH];        // Expected RAM contents

// Numerical Recipes multiplier and increment
function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Random word from two draws, low bits of an LCG are weak so skip them
function automatic logic [DATA_W-1:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return DATA_W'({hi, lo} >> 8);
endfunction

function automatic logic [ADDR_W-1:0] rand_addr();
    logic [31:0] r;
    r = lcg_next();
    return ADDR_W'((r >> 8) % DEPTH); // Always inside the array
endfunction

// Offset may be slightly negative for words just below a range
function automatic logic [ADDR_W-1:0] wrap_addr(input logic [ADDR_W-1:0] base, input int offset);
    return ADDR_W'((int'(base) + offset + DEPTH) % DEPTH);
endfunction

// Same walk as a range fill, wrapping at DEPTH
task automatic model_fill(input logic [ADDR_W-1:0] base, input int count,
                          input logic [DATA_W-1:0] value);
    for (int k = 0; k < count; k++) begin
        model_mem[wrap_addr(base, k)] = value;
    end
endtask

`endif

// File: test/tb_nx_node_memory.sv
/*
 * Testbench for the node memory top level
 * Clock, reset, random host messages and range commands
 * Responses checked against a reference memory model
 */
`timescale 1ns/1ps

module tb_nx_node_memory;

    import nx_mem_pkg::*;

    localparam int ADDR_W    = 10;
    localparam int DATA_W    = 36;
    localparam int DEPTH     = 1024;
    localparam int TAG_W     = 4;
    localparam int CNT_W     = 11;
    localparam int CLK_HALF  = 50; // 100 ns period
    localparam int DRIVE_DLY = 1;  // Inputs change this long after the edge

    logic               clk_a_i;
    logic               rst_a_i;
    logic               msg_valid_i;
    nx_msg_op_t         msg_op_i;
    logic [TAG_W-1:0]   msg_tag_i;
    logic [ADDR_W-1:0]  msg_addr_i;
    logic [DATA_W-1:0]  msg_data_i;
    logic               rsp_valid_o;
    logic [TAG_W-1:0]   rsp_tag_o;
    logic [DATA_W-1:0]  rsp_data_o;
    logic               cmd_start_i;
    nx_range_op_t       cmd_op_i;
    logic [ADDR_W-1:0]  cmd_addr_i;
    logic [CNT_W-1:0]   cmd_count_i;
    logic [DATA_W-1:0]  cmd_fill_i;
    logic               busy_o;
    logic               stream_valid_o;
    logic [DATA_W-1:0]  stream_data_o;
    logic               done_o;

    `include "nx_tb_model.svh"

    nx_node_memory u_dut (
          .clk_a_i       (clk_a_i)
        , .rst_a_i       (rst_a_i)
        , .msg_valid_i   (msg_valid_i)
        , .msg_op_i      (msg_op_i)
        , .msg_tag_i     (msg_tag_i)
        , .msg_addr_i    (msg_addr_i)
        , .msg_data_i    (msg_data_i)
        , .rsp_valid_o   (rsp_valid_o)
        , .rsp_tag_o     (rsp_tag_o)
        , .rsp_data_o    (rsp_data_o)
        , .cmd_start_i   (cmd_start_i)
        , .cmd_op_i      (cmd_op_i)
        , .cmd_addr_i    (cmd_addr_i)
        , .cmd_count_i   (cmd_count_i)
        , .cmd_fill_i    (cmd_fill_i)
        , .busy_o        (busy_o)
        , .stream_valid_o(stream_valid_o)
        , .stream_data_o (stream_data_o)
        , .done_o        (done_o)
    );

    initial begin : gen_clk
        clk_a_i = 1'b0;
        forever #CLK_HALF clk_a_i = ~clk_a_i;
    end

    // Next cycle, just past the edge where outputs have settled
    task automatic step();
        @(posedge clk_a_i);
        #DRIVE_DLY;
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopping at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act)
            else fail_run($sformatf("Error in %s expected 0x%0h actual 0x%0h", name, exp, act));
    endtask

    // One write message, nothing comes back
    task automatic host_write(input string name, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data);
        logic [31:0] r;
        r = lcg_next();
        msg_valid_i = 1'b1;
        msg_op_i    = MSG_WRITE;
        msg_tag_i   = r[23:20]; // Tag is ignored on writes
        msg_addr_i  = addr;
        msg_data_i  = data;
        model_mem[addr] = data;
        step();
        msg_valid_i = 1'b0;
        check_value({name, " rsp_valid_o after write"}, 64'(1'b0), 64'(rsp_valid_o));
    endtask

    // One read message, response due in the very next cycle
    task automatic host_read(input string name, input logic [ADDR_W-1:0] addr);
        logic [31:0]       r;
        logic [DATA_W-1:0] exp_data;
        logic [TAG_W-1:0]  tag;
        r        = lcg_next();
        tag      = r[23:20];
        exp_data = model_mem[addr]; // Contents as they stand before this read
        msg_valid_i = 1'b1;
        msg_op_i    = MSG_READ;
        msg_tag_i   = tag;
        msg_addr_i  = addr;
        msg_data_i  = rand_word(); // Must be ignored
        step();
        msg_valid_i = 1'b0;
        check_value({name, " rsp_valid_o"}, 64'(1'b1), 64'(rsp_valid_o));
        check_value({name, " rsp_tag_o"}, 64'(tag), 64'(rsp_tag_o));
        check_value({name, " rsp_data_o"}, 64'(exp_data), 64'(rsp_data_o));
    endtask

    // Start is driven in the current cycle, returns in the done cycle
    task automatic run_range(input string name, input nx_range_op_t op,
                             input logic [ADDR_W-1:0] base, input int count,
                             input logic [DATA_W-1:0] fill);
        int cyc;
        bit done_seen;
        cmd_start_i = 1'b1;
        cmd_op_i    = op;
        cmd_addr_i  = base;
        cmd_count_i = CNT_W'(count);
        cmd_fill_i  = fill;
        if (op == RANGE_FILL) begin
            model_fill(base, count, fill);
        end
        cyc       = 0;
        done_seen = 1'b0;
        while (!done_seen) begin
            step();
            cmd_start_i = 1'b0;
            cyc++;
            if (cyc > count + 4) begin
                fail_run($sformatf("Timeout in %s, done_o did not rise within %0d cycles",
                                   name, count + 4));
            end
            check_value({name, " busy_o"}, 64'(cyc <= count), 64'(busy_o));
            check_value({name, " done_o"}, 64'(cyc == count + 1), 64'(done_o));
            check_value({name, " stream_valid_o"},
                        64'(op == RANGE_READ && cyc >= 2 && cyc <= count + 1),
                        64'(stream_valid_o));
            if (stream_valid_o) begin // Words arrive in address order
                check_value({name, " stream_data_o"},
                            64'(model_mem[wrap_addr(base, cyc - 2)]), 64'(stream_data_o));
            end
            done_seen = done_o;
        end
    endtask

    initial begin : run_tests
        logic [31:0]       r;
        logic [ADDR_W-1:0] base;
        logic [ADDR_W-1:0] addr_list [8];
        int                count;
        rst_a_i     = 1'b1;
        msg_valid_i = 1'b0;
        msg_op_i    = MSG_READ;
        msg_tag_i   = '0;
        msg_addr_i  = '0;
        msg_data_i  = '0;
        cmd_start_i = 1'b0;
        cmd_op_i    = RANGE_READ;
        cmd_addr_i  = '0;
        cmd_count_i = '0;
        cmd_fill_i  = '0;
        repeat (16) step();
        rst_a_i = 1'b0;
        step();
        check_value("after reset rsp_valid_o", 64'(1'b0), 64'(rsp_valid_o));
        check_value("after reset stream_valid_o", 64'(1'b0), 64'(stream_valid_o));
        check_value("after reset done_o", 64'(1'b0), 64'(done_o));
        check_value("after reset busy_o", 64'(1'b0), 64'(busy_o));

        // Every word defined before anything reads it
        for (int a = 0; a < DEPTH; a++) begin
            host_write("preload", ADDR_W'(a), rand_word());
        end

        for (int k = 0; k < 8; k++) begin
            addr_list[k] = rand_addr();
            host_write("write then read", addr_list[k], rand_word());
        end
        for (int k = 0; k < 8; k++) begin
            host_read("write then read", addr_list[k]);
        end

        // Small window so reads often hit a word written a cycle earlier
        for (int k = 0; k < 300; k++) begin
            r = lcg_next();
            if (r[31]) host_write("back-to-back", ADDR_W'(r[27:24]), rand_word());
            else       host_read("back-to-back", ADDR_W'(r[27:24]));
        end

        r = lcg_next();
        run_range("range read", RANGE_READ, rand_addr(), 1 + int'((r >> 8) % 64), '0);
        step();
        r    = lcg_next();
        base = ADDR_W'(DEPTH - 1 - int'((r >> 8) % 4));
        run_range("range read wrap", RANGE_READ, base, 8 + int'((r >> 16) % 16), '0);
        step();

        r     = lcg_next();
        base  = rand_addr();
        count = 1 + int'((r >> 8) % 40);
        run_range("range fill", RANGE_FILL, base, count, rand_word());
        for (int k = -2; k < count + 2; k++) begin // Two neighbours on each side
            host_read("range fill readback", wrap_addr(base, k));
        end

        // Each start lands in the done cycle of the one before
        for (int k = 0; k < 4; k++) begin
            r = lcg_next();
            run_range("back-to-back commands", r[31] ? RANGE_FILL : RANGE_READ,
                      rand_addr(), 1 + int'((r >> 8) % 24), rand_word());
        end
        step();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule : tb_nx_node_memory
